// ==== list.f ====
design/fpu_pkg.sv
design/f_register_file.sv
design/fpu_decode.sv
design/fpu_execute.sv
design/fpu_result.sv
design/fpu_top.sv
verif/fpu_props.sv
verif/fpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module fpu_tb -Mdir obj_dir -o fpu_sim -f list.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/fpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
exit 0

// ==== verif/fpu_tb.sv ====
`default_nettype none

module fpu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fpu_pkg::*;

  // ##################################################
  // Run length
  // ##################################################

  // Instructions issued by tests 1 to 6
  localparam int N_INSTR     = 64 + 60 + 4 * 144 + 3 * 144 + 12 + 200;
  // Flag clears in tests 3, 4 and 6
  localparam int N_CLEAR     = 2 * 144 + 3 * 144 + 200 + 1;
  // Up to two stall cycles per issue, one per clear, plus reset and drain
  localparam int CYCLE_LIMIT = 10 + 3 * N_INSTR + N_CLEAR + 50;

  // Expected outcome of one instruction
  typedef struct packed {
    word_t  value;
    logic   int_dest;
    flags_t flags;
    logic   illegal;
  } ref_t;

  // Pending check, due when the outputs show it
  typedef struct packed {
    logic [31:0] due;
    logic        int_dest;
    logic        illegal;
    word_t       value;
    reg_idx_t    rd;
    flags_t      flags;
  } pend_t;

  logic     CLK;
  logic     nRST;
  logic     instr_valid;
  instr_t   instr;
  word_t    int_src;
  logic     flags_clear;
  logic     int_valid;
  word_t    int_result;
  reg_idx_t int_rd;
  logic     illegal;
  flags_t   fflags;

  integer   seed = 32'hae7f_c90e;
  int       cyc = 0;
  int       checks = 0;
  int       errors = 0;
  int       test_errs = 0;
  int       hist0 = -1;          // fp dest of previous slot
  int       hist1 = -1;          // fp dest two slots back
  int       clr_due = -1;
  flags_t   exp_flags = '0;
  word_t    shadow [32];
  pend_t    pend_q [$];
  word_t    specials [12] = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
                             32'h7FC0_0000, 32'h7F80_0001, 32'hFFC0_0001, 32'hFF80_0123,
                             32'h3F80_0000, 32'hC000_0000, 32'h0000_0001, 32'h807F_FFFF};

  fpu_top #(
    .NUM_REGS (32)
  ) uut (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr       (instr),
    .int_src     (int_src),
    .flags_clear (flags_clear),
    .int_valid   (int_valid),
    .int_result  (int_result),
    .int_rd      (int_rd),
    .illegal     (illegal),
    .fflags      (fflags)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) cyc <= cyc + 1;

  // ##################################################
  // Reference model
  // ##################################################

  function automatic logic is_nan(word_t x);
    return (x[30:23] == 8'hFF) && (x[22:0] != 0);
  endfunction

  function automatic logic is_snan(word_t x);
    return is_nan(x) && !x[22];
  endfunction

  // Monotonic key, -0 sorts below +0
  function automatic logic [31:0] order_key(word_t x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic logic [9:0] class_mask(word_t x);
    int idx;
    if (x[30:23] == 8'hFF) begin
      idx = (x[22:0] == 0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
    end else if (x[30:23] == 8'h00) begin
      idx = (x[22:0] == 0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
    end else begin
      idx = x[31] ? 1 : 6;
    end
    return 10'b1 << idx;
  endfunction

  function automatic ref_t ref_model(fpu_op_e op, word_t a, word_t b, word_t isrc);
    ref_t r;
    logic nan_any;
    logic snan_any;
    logic zeros;
    logic a_less;
    r        = '0;
    nan_any  = is_nan(a) || is_nan(b);
    snan_any = is_snan(a) || is_snan(b);
    zeros    = (a[30:0] == 0) && (b[30:0] == 0);
    a_less   = order_key(a) < order_key(b);
    r.int_dest = (op == OP_FEQ) || (op == OP_FLT) || (op == OP_FLE) ||
                 (op == OP_FCLASS) || (op == OP_FMV_X_W);
    case (op)
      OP_FSGNJ:  r.value = {b[31], a[30:0]};
      OP_FSGNJN: r.value = {!b[31], a[30:0]};
      OP_FSGNJX: r.value = {a[31] ^ b[31], a[30:0]};
      OP_FMIN, OP_FMAX: begin
        if (is_nan(a) && is_nan(b)) r.value = 32'h7FC0_0000;  // Canonical NaN
        else if (is_nan(a)) r.value = b;
        else if (is_nan(b)) r.value = a;
        else r.value = ((op == OP_FMIN) == a_less) ? a : b;
        r.flags[FLAG_NV] = snan_any;
      end
      OP_FEQ: begin
        r.value = 32'(!nan_any && (a == b || zeros));
        r.flags[FLAG_NV] = snan_any;
      end
      OP_FLT: begin
        r.value = 32'(!nan_any && !zeros && a_less);
        r.flags[FLAG_NV] = nan_any;
      end
      OP_FLE: begin
        r.value = 32'(!nan_any && (zeros || a_less || a == b));
        r.flags[FLAG_NV] = nan_any;
      end
      OP_FCLASS:  r.value = {22'b0, class_mask(a)};
      OP_FMV_X_W: r.value = a;
      OP_FMV_W_X: r.value = isrc;
      default:    r.illegal = 1'b1;
    endcase
    return r;
  endfunction

  function automatic instr_t encode(fpu_op_e op, reg_idx_t rd, reg_idx_t r1, reg_idx_t r2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = 7'b0010000;
    f3 = 3'b011;               // Unused SGNJ funct3, illegal
    case (op)
      OP_FSGNJ:   f3 = 3'd0;
      OP_FSGNJN:  f3 = 3'd1;
      OP_FSGNJX:  f3 = 3'd2;
      OP_FMIN: begin
        f7 = 7'b0010100;
        f3 = 3'd0;
      end
      OP_FMAX: begin
        f7 = 7'b0010100;
        f3 = 3'd1;
      end
      OP_FEQ: begin
        f7 = 7'b1010000;
        f3 = 3'd2;
      end
      OP_FLT: begin
        f7 = 7'b1010000;
        f3 = 3'd1;
      end
      OP_FLE: begin
        f7 = 7'b1010000;
        f3 = 3'd0;
      end
      OP_FCLASS: begin
        f7 = 7'b1110000;
        f3 = 3'd1;
        r2 = '0;
      end
      OP_FMV_X_W: begin
        f7 = 7'b1110000;
        f3 = 3'd0;
        r2 = '0;
      end
      OP_FMV_W_X: begin
        f7 = 7'b1111000;
        f3 = 3'd0;
        r2 = '0;
      end
      default:    f3 = 3'b011;
    endcase
    return {f7, r2, r1, f3, rd, 7'b1010011};
  endfunction

  // ##################################################
  // Drive tasks
  // ##################################################

  function automatic logic busy(reg_idx_t r);
    return (int'(r) == hist0) || (int'(r) == hist1);
  endfunction

  task automatic idle_cycle();
    @(posedge CLK);
    #5;
    instr_valid = 1'b0;
    flags_clear = 1'b0;
    hist1 = hist0;
    hist0 = -1;
  endtask

  task automatic clear_flags();
    @(posedge CLK);
    #5;
    instr_valid = 1'b0;
    flags_clear = 1'b1;
    clr_due = cyc + 1;         // Takes effect at next edge
    hist1 = hist0;
    hist0 = -1;
  endtask

  task automatic issue(fpu_op_e op, reg_idx_t rd, reg_idx_t r1, reg_idx_t r2, word_t isrc);
    ref_t  r;
    pend_t p;
    logic  need1;
    logic  need2;
    need1 = (op != OP_FMV_W_X) && (op != OP_NONE);
    need2 = need1 && (op != OP_FCLASS) && (op != OP_FMV_X_W);
    while ((need1 && busy(r1)) || (need2 && busy(r2))) idle_cycle();
    @(posedge CLK);
    #5;
    flags_clear = 1'b0;
    instr_valid = 1'b1;
    instr       = encode(op, rd, r1, r2);
    int_src     = isrc;
    r = ref_model(op, shadow[r1], shadow[r2], isrc);
    p = '{due: cyc + 3, int_dest: r.int_dest, illegal: r.illegal,
          value: r.value, rd: rd, flags: r.flags};
    pend_q.push_back(p);
    hist1 = hist0;
    hist0 = -1;
    if (!r.int_dest && !r.illegal) begin
      shadow[rd] = r.value;
      hist0 = int'(rd);
    end
  endtask

  task automatic drain(string name);
    while (pend_q.size() != 0) idle_cycle();
    $display("test %s: %0d errors", name, errors - test_errs);
    test_errs = errors;
  endtask

  function automatic reg_idx_t rand_reg(int base, int span);
    return reg_idx_t'(base + ($unsigned($random(seed)) % span));
  endfunction

  // ##################################################
  // Comparison
  // ##################################################

  task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  always @(negedge CLK) begin
    pend_t e;
    logic  exp_iv;
    logic  exp_ill;
    if (nRST) begin
      exp_iv  = 1'b0;
      exp_ill = 1'b0;
      if (clr_due == cyc) exp_flags = '0;
      if (pend_q.size() != 0 && pend_q[0].due == cyc) begin
        e = pend_q.pop_front();
        exp_flags |= e.flags;
        exp_iv    = e.int_dest && !e.illegal;
        exp_ill   = e.illegal;
        if (exp_iv) begin
          check_eq("int_result", int_result, e.value);
          check_eq("int_rd", 32'(int_rd), 32'(e.rd));
        end
      end
      check_eq("int_valid", 32'(int_valid), 32'(exp_iv));
      check_eq("illegal", 32'(illegal), 32'(exp_ill));
      check_eq("fflags", 32'(fflags), 32'(exp_flags));
    end
  end

  initial begin
    while (cyc < CYCLE_LIMIT) @(posedge CLK);
    $display("Timeout, results still missing after %0d cycles", CYCLE_LIMIT);
    $display("TEST FAIL");
    $finish;
  end

  // ##################################################
  // Tests
  // ##################################################

  initial begin
    fpu_op_e  op;
    reg_idx_t rd;
    nRST        = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    int_src     = '0;
    flags_clear = 1'b0;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    repeat (10) @(posedge CLK);
    #5 nRST = 1'b1;

    // 1: load all registers, specials in f1..f12
    for (int i = 0; i < 32; i++) begin
      issue(OP_FMV_W_X, reg_idx_t'(i), '0, '0,
            (i >= 1 && i <= 12) ? specials[i - 1] : word_t'($random(seed)));
    end
    for (int i = 0; i < 32; i++) issue(OP_FMV_X_W, rand_reg(0, 32), reg_idx_t'(i), '0, '0);
    drain("move round trip");

    // 2: sign injection, results kept out of f0..f12
    for (int k = 0; k < 30; k++) begin
      op = fpu_op_e'(int'(OP_FSGNJ) + k % 3);
      rd = rand_reg(13, 19);
      issue(op, rd, rand_reg(0, 32), rand_reg(0, 32), '0);
      issue(OP_FMV_X_W, rand_reg(0, 32), rd, '0, '0);
    end
    drain("sign injection");

    // 3: min and max over every special pair
    for (int i = 1; i <= 12; i++) begin
      for (int j = 1; j <= 12; j++) begin
        for (int m = 0; m < 2; m++) begin
          rd = reg_idx_t'(13 + (i * 12 + j + m) % 19);
          clear_flags();       // NV of this op alone
          issue(m ? OP_FMAX : OP_FMIN, rd, reg_idx_t'(i), reg_idx_t'(j), '0);
          issue(OP_FMV_X_W, rand_reg(0, 32), rd, '0, '0);
        end
      end
    end
    drain("min max");

    // 4: compares, each with fresh flags
    for (int i = 1; i <= 12; i++) begin
      for (int j = 1; j <= 12; j++) begin
        clear_flags();
        issue(OP_FEQ, rand_reg(0, 32), reg_idx_t'(i), reg_idx_t'(j), '0);
        clear_flags();
        issue(OP_FLT, rand_reg(0, 32), reg_idx_t'(i), reg_idx_t'(j), '0);
        clear_flags();
        issue(OP_FLE, rand_reg(0, 32), reg_idx_t'(i), reg_idx_t'(j), '0);
      end
    end
    drain("compare");

    // 5: one register per class, two classes twice
    for (int i = 1; i <= 12; i++) issue(OP_FCLASS, rand_reg(0, 32), reg_idx_t'(i), '0, '0);
    drain("classify");

    // 6: back-to-back random mix, occasional flag clear
    for (int k = 0; k < 200; k++) begin
      if ($unsigned($random(seed)) % 16 == 0) clear_flags();
      op = fpu_op_e'($unsigned($random(seed)) % 12);
      if (op inside {OP_FEQ, OP_FLT, OP_FLE, OP_FCLASS, OP_FMV_X_W, OP_NONE}) begin
        rd = rand_reg(0, 32);
      end else begin
        rd = rand_reg(13, 19);
      end
      issue(op, rd, rand_reg(0, 32), rand_reg(0, 32), word_t'($random(seed)));
    end
    clear_flags();
    drain("random mix");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/fpu_props.sv ====
`default_nettype none

module fpu_props (
  input wire logic             CLK,
  input wire logic             nRST,
  input wire logic             instr_valid,
  input wire logic             flags_clear,
  input wire logic             exe_valid,    // Result stage busy
  input wire logic             int_valid,
  input wire logic             illegal,
  input wire fpu_pkg::flags_t  fflags
);

  timeunit 1ns;
  timeprecision 100ps;

  // One outcome per instruction
  strobe_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(int_valid && illegal)) else $error("int_valid and illegal high together");

  // Fixed three-cycle latency
  int_latency: assert property (@(posedge CLK) disable iff (!nRST)
    int_valid |-> $past(instr_valid, 3)) else $error("int_valid without issue");

  // ################################################
  // Sticky flag register moves only for a cause
  flag_cause: assert property (@(posedge CLK) disable iff (!nRST)
    $changed(fflags) |-> ($past(flags_clear) || $past(exe_valid)))
    else $error("fflags changed with no result or clear");

endmodule

bind fpu_top fpu_props u_props (
  .CLK         (CLK),
  .nRST        (nRST),
  .instr_valid (instr_valid),
  .flags_clear (flags_clear),
  .exe_valid   (exe.valid),
  .int_valid   (int_valid),
  .illegal     (illegal),
  .fflags      (fflags)
);

`default_nettype wire

// ==== design/fpu_top.sv ====
`default_nettype none

module fpu_top #(
  parameter int NUM_REGS = 32
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             instr_valid,
  input  fpu_pkg::instr_t   instr,
  input  fpu_pkg::word_t    int_src,
  input  logic             flags_clear,
  output logic             int_valid,
  output fpu_pkg::word_t    int_result,
  output fpu_pkg::reg_idx_t int_rd,
  output logic             illegal,
  output fpu_pkg::flags_t   fflags
);

  import fpu_pkg::*;

  // Register file hookup
  reg_idx_t   rf_rs1;
  reg_idx_t   rf_rs2;
  word_t      rf_rs1_data;
  word_t      rf_rs2_data;
  logic       rf_wen;
  reg_idx_t   rf_waddr;
  word_t      rf_wdata;

  // Stage registers
  dec_stage_t dec;
  exe_stage_t exe;

  // ################################################
  // Three-stage pipeline
  // ################################################

  fpu_decode u_decode (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr       (instr),
    .int_src     (int_src),
    .rs1         (rf_rs1),
    .rs2         (rf_rs2),
    .rs1_data    (rf_rs1_data),
    .rs2_data    (rf_rs2_data),
    .dec         (dec)
  );

  fpu_execute u_execute (
    .CLK  (CLK),
    .nRST (nRST),
    .dec  (dec),
    .exe  (exe)
  );

  fpu_result u_result (
    .CLK         (CLK),
    .nRST        (nRST),
    .exe         (exe),
    .flags_clear (flags_clear),
    .wen         (rf_wen),
    .waddr       (rf_waddr),
    .wdata       (rf_wdata),
    .int_valid   (int_valid),
    .int_result  (int_result),
    .int_rd      (int_rd),
    .illegal     (illegal),
    .fflags      (fflags)
  );

  // Read in decode, written back from result
  f_register_file #(
    .NUM_REGS (NUM_REGS)
  ) u_frf (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (rf_rs1),
    .rs2      (rf_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .wen      (rf_wen),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

endmodule

`default_nettype wire

// ==== design/fpu_result.sv ====
`default_nettype none

module fpu_result (
  input  logic               CLK,
  input  logic               nRST,
  input  fpu_pkg::exe_stage_t exe,
  input  logic               flags_clear,  // Zeroes fflags
  // Register file write
  output logic               wen,
  output fpu_pkg::reg_idx_t   waddr,
  output fpu_pkg::word_t      wdata,
  // Integer result port
  output logic               int_valid,
  output fpu_pkg::word_t      int_result,
  output fpu_pkg::reg_idx_t   int_rd,
  output logic               illegal,
  output fpu_pkg::flags_t     fflags
);

  logic legal;
  logic to_int;

  assign legal  = exe.valid & ~exe.illegal;
  assign to_int = legal & exe.int_dest;

  // f-register writeback, lands at the next edge
  assign wen   = legal & ~exe.int_dest;
  assign waddr = exe.rd;
  assign wdata = exe.value;

  // ################################################
  // Strobes and sticky flags
  // ################################################

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      int_valid <= 1'b0;
      illegal   <= 1'b0;
      fflags    <= '0;
    end else begin
      int_valid <= to_int;                  // One-cycle pulse
      illegal   <= exe.valid & exe.illegal;
      // Clear drops the old value, new flags still accrue
      fflags    <= (flags_clear ? '0 : fflags) | (legal ? exe.flags : '0);
    end
  end

  // Integer payload, qualified by int_valid
  always_ff @(posedge CLK) begin
    if (to_int) begin
      int_result <= exe.value;
      int_rd     <= exe.rd;
    end
  end

endmodule

`default_nettype wire

// ==== design/fpu_execute.sv ====
`default_nettype none

module fpu_execute (
  input  logic               CLK,
  input  logic               nRST,
  input  fpu_pkg::dec_stage_t dec,
  output fpu_pkg::exe_stage_t exe
);

  import fpu_pkg::*;

  localparam word_t CANON_NAN = 32'h7FC0_0000;

  // ################################################
  // Classification
  // ################################################

  // One-hot FCLASS mask, bit order per the F spec
  function automatic logic [9:0] fclass(word_t x);
    logic       sgn;
    logic       exp_max;
    logic       exp_zero;
    logic       man_zero;
    logic [9:0] cls;
    sgn      = x[31];
    exp_max  = (x[30:23] == 8'hFF);
    exp_zero = (x[30:23] == 8'h00);
    man_zero = (x[22:0] == '0);
    cls      = '0;
    if (exp_max) begin
      if (man_zero) begin
        cls[sgn ? 0 : 7] = 1'b1;  // Infinity
      end else if (x[22]) begin
        cls[9] = 1'b1;            // Quiet NaN
      end else begin
        cls[8] = 1'b1;            // Signaling NaN
      end
    end else if (exp_zero) begin
      if (man_zero) begin
        cls[sgn ? 3 : 4] = 1'b1;  // Zero
      end else begin
        cls[sgn ? 2 : 5] = 1'b1;  // Subnormal
      end
    end else begin
      cls[sgn ? 1 : 6] = 1'b1;    // Normal
    end
    return cls;
  endfunction

  word_t      a;
  word_t      b;
  logic [9:0] cls_a;
  logic [9:0] cls_b;
  logic       a_nan;
  logic       b_nan;
  logic       any_nan;
  logic       any_snan;
  logic       both_zero;
  logic       lt;         // a < b, zeros equal
  logic       eq;
  logic       lt_mm;      // a < b with -0 < +0
  word_t      min_val;
  word_t      max_val;
  exe_stage_t exe_next;

  assign a     = dec.operand_a;
  assign b     = dec.operand_b;
  assign cls_a = fclass(a);
  assign cls_b = fclass(b);

  assign a_nan     = cls_a[8] | cls_a[9];
  assign b_nan     = cls_b[8] | cls_b[9];
  assign any_nan   = a_nan | b_nan;
  assign any_snan  = cls_a[8] | cls_b[8];
  assign both_zero = (cls_a[3] | cls_a[4]) & (cls_b[3] | cls_b[4]);

  // ################################################
  // Ordering, NaNs excluded later
  // ################################################

  always_comb begin
    if (a[31] != b[31]) begin
      lt = a[31] & ~both_zero;      // Negative below positive
    end else if (a[31]) begin
      lt = (b[30:0] < a[30:0]);     // Both negative, larger magnitude is smaller
    end else begin
      lt = (a[30:0] < b[30:0]);
    end
  end

  assign eq    = (a == b) | both_zero;
  assign lt_mm = lt | (both_zero & a[31] & ~b[31]);

  // min/max NaN handling
  always_comb begin
    if (a_nan && b_nan) begin
      min_val = CANON_NAN;
      max_val = CANON_NAN;
    end else if (a_nan) begin
      min_val = b;  // Other operand wins
      max_val = b;
    end else if (b_nan) begin
      min_val = a;
      max_val = a;
    end else begin
      min_val = lt_mm ? a : b;
      max_val = lt_mm ? b : a;
    end
  end

  // ################################################
  // Result select
  // ################################################

  always_comb begin
    exe_next          = '0;
    exe_next.valid    = dec.valid;
    exe_next.illegal  = dec.illegal;
    exe_next.rd       = dec.rd;
    exe_next.int_dest = dec.int_dest;
    case (dec.op)
      OP_FSGNJ:   exe_next.value = {b[31], a[30:0]};
      OP_FSGNJN:  exe_next.value = {~b[31], a[30:0]};
      OP_FSGNJX:  exe_next.value = {a[31] ^ b[31], a[30:0]};
      OP_FMIN: begin
        exe_next.value          = min_val;
        exe_next.flags[FLAG_NV] = any_snan;
      end
      OP_FMAX: begin
        exe_next.value          = max_val;
        exe_next.flags[FLAG_NV] = any_snan;
      end
      OP_FEQ: begin
        exe_next.value          = {31'b0, eq & ~any_nan};
        exe_next.flags[FLAG_NV] = any_snan;  // Quiet compare
      end
      OP_FLT: begin
        exe_next.value          = {31'b0, lt & ~any_nan};
        exe_next.flags[FLAG_NV] = any_nan;   // Signaling compare
      end
      OP_FLE: begin
        exe_next.value          = {31'b0, (lt | eq) & ~any_nan};
        exe_next.flags[FLAG_NV] = any_nan;
      end
      OP_FCLASS:  exe_next.value = {22'b0, cls_a};
      OP_FMV_X_W: exe_next.value = a;  // Raw bit move
      OP_FMV_W_X: exe_next.value = a;  // int_src already muxed in
      default:    exe_next.value = '0;
    endcase
    if (!dec.valid) begin
      exe_next.flags = '0;  // Bubbles raise nothing
    end
  end

  // Execute stage register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exe <= '0;
    end else begin
      exe <= exe_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/fpu_decode.sv ====
`default_nettype none

module fpu_decode (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               instr_valid,  // Single-cycle issue strobe
  input  fpu_pkg::instr_t     instr,
  input  fpu_pkg::word_t      int_src,      // x[rs1] for FMV.W.X
  // Register file read
  output fpu_pkg::reg_idx_t   rs1,
  output fpu_pkg::reg_idx_t   rs2,
  input  fpu_pkg::word_t      rs1_data,
  input  fpu_pkg::word_t      rs2_data,
  output fpu_pkg::dec_stage_t dec
);

  import fpu_pkg::*;

  localparam logic [6:0] OPC_OP_FP = 7'b1010011;

  // funct7 groups within OP-FP, single precision (fmt = 00)
  localparam logic [6:0] F7_SGNJ   = 7'b0010000;
  localparam logic [6:0] F7_MINMAX = 7'b0010100;
  localparam logic [6:0] F7_CMP    = 7'b1010000;
  localparam logic [6:0] F7_MV_X_W = 7'b1110000;  // Shared with FCLASS
  localparam logic [6:0] F7_MV_W_X = 7'b1111000;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       rs2_zero;
  fpu_op_e    op;
  logic       int_dest;
  dec_stage_t dec_next;

  // Field split
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign rs2_zero = (rs2 == '0);  // Required by unary ops

  // ################################################
  // Encoding match
  // ################################################

  always_comb begin
    op = OP_NONE;
    if (opcode == OPC_OP_FP) begin
      case (funct7)
        F7_SGNJ: begin
          case (funct3)
            3'b000:  op = OP_FSGNJ;
            3'b001:  op = OP_FSGNJN;
            3'b010:  op = OP_FSGNJX;
            default: op = OP_NONE;
          endcase
        end
        F7_MINMAX: begin
          if (funct3 == 3'b000) begin
            op = OP_FMIN;
          end else if (funct3 == 3'b001) begin
            op = OP_FMAX;
          end
        end
        F7_CMP: begin
          case (funct3)
            3'b010:  op = OP_FEQ;
            3'b001:  op = OP_FLT;
            3'b000:  op = OP_FLE;
            default: op = OP_NONE;
          endcase
        end
        F7_MV_X_W: begin
          if (rs2_zero && funct3 == 3'b000) begin
            op = OP_FMV_X_W;
          end else if (rs2_zero && funct3 == 3'b001) begin
            op = OP_FCLASS;
          end
        end
        F7_MV_W_X: begin
          if (rs2_zero && funct3 == 3'b000) begin
            op = OP_FMV_W_X;
          end
        end
        default: op = OP_NONE;
      endcase
    end
  end

  // Ops whose result lands in x[rd]
  assign int_dest = (op == OP_FEQ) || (op == OP_FLT) || (op == OP_FLE) ||
                    (op == OP_FCLASS) || (op == OP_FMV_X_W);

  always_comb begin
    dec_next           = '0;
    dec_next.valid     = instr_valid;
    dec_next.illegal   = instr_valid && (op == OP_NONE);
    dec_next.op        = op;
    dec_next.rd        = instr[11:7];
    dec_next.operand_a = (op == OP_FMV_W_X) ? int_src : rs1_data;  // Integer source bypass
    dec_next.operand_b = rs2_data;
    dec_next.int_dest  = int_dest;
  end

  // Decode stage register, loads at issue edge
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dec <= '0;
    end else begin
      dec <= dec_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/f_register_file.sv ====
`default_nettype none

module f_register_file #(
  parameter int NUM_REGS = 32
) (
  input  logic             CLK,
  input  logic             nRST,
  // Read ports, combinational
  input  fpu_pkg::reg_idx_t rs1,
  input  fpu_pkg::reg_idx_t rs2,
  output fpu_pkg::word_t    rs1_data,
  output fpu_pkg::word_t    rs2_data,
  // Write port, clocked
  input  logic             wen,
  input  fpu_pkg::reg_idx_t waddr,
  input  fpu_pkg::word_t    wdata
);

  import fpu_pkg::*;

  word_t registers [NUM_REGS];  // f0 .. f(N-1)

  // ################################################
  // Write side
  // ################################################

  // f0 is an ordinary register here, no hardwired zero
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      registers <= '{default: '0};  // Whole file cleared
    end else if (wen && (int'(waddr) < NUM_REGS)) begin
      registers[waddr] <= wdata;
    end
  end

  // ################################################
  // Read side
  // ################################################

  // Out-of-range index reads as zero
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (int'(rs1) < NUM_REGS) begin
      rs1_data = registers[rs1];
    end
    if (int'(rs2) < NUM_REGS) begin
      rs2_data = registers[rs2];
    end
  end

endmodule

`default_nettype wire

// ==== design/fpu_pkg.sv ====
`default_nettype none

package fpu_pkg;

  // ################################################
  // Basic widths
  // ################################################

  typedef logic [31:0] word_t;     // IEEE single or integer result
  typedef logic [31:0] instr_t;    // Raw RV32 instruction word
  typedef logic [4:0]  reg_idx_t;  // f or x register index
  typedef logic [4:0]  flags_t;    // {NV, DZ, OF, UF, NX}

  // Invalid operation, the only flag this unit raises
  localparam int FLAG_NV = 4;

  // ################################################
  // Operations
  // ################################################

  typedef enum logic [3:0] {
    OP_NONE,     // Unrecognized encoding
    OP_FSGNJ,
    OP_FSGNJN,
    OP_FSGNJX,
    OP_FMIN,
    OP_FMAX,
    OP_FEQ,
    OP_FLT,
    OP_FLE,
    OP_FCLASS,
    OP_FMV_X_W,  // f -> x, bit copy
    OP_FMV_W_X   // x -> f, bit copy
  } fpu_op_e;

  // ################################################
  // Pipeline stage registers
  // ################################################

  // Decode -> execute
  typedef struct packed {
    logic     valid;
    logic     illegal;    // Encoding not matched
    fpu_op_e  op;
    reg_idx_t rd;
    word_t    operand_a;  // rs1 data, or int_src for FMV.W.X
    word_t    operand_b;  // rs2 data
    logic     int_dest;   // Result goes to x register
  } dec_stage_t;

  // Execute -> result
  typedef struct packed {
    logic     valid;
    logic     illegal;
    reg_idx_t rd;
    logic     int_dest;
    word_t    value;      // Final result word
    flags_t   flags;      // Exceptions of this instruction only
  } exe_stage_t;

endpackage

`default_nettype wire
